/* disp_consts.svh */
`ifndef DISP_CONSTS_SVH
`define DISP_CONSTS_SVH

////////////////////////////////
// Port and datapath widths
////////////////////////////////

// Register port byte address and word index
`define DISP_REG_AW      8
`define DISP_REG_IDX_LSB 2
`define DISP_REG_IDX_W   6

`define DISP_DATA_W      32
`define DISP_CNT_W       16
`define DISP_FB_DIM_W    12
`define DISP_COLOR_W     24
`define DISP_CH_W        8

// Words per line buffer bank are 2**DISP_LB_WORD_AW
`define DISP_LB_WORD_AW  8

////////////////////////////////
// Register field positions
////////////////////////////////

`define DISP_POL_H_BIT    0
`define DISP_POL_V_BIT    1

// Depth register, bit 0 selects 16 bpp, bit 1 enables fetch
`define DISP_DEPTH_BIT    0
`define DISP_FETCH_EN_BIT 1

////////////////////////////////
// Reset defaults
////////////////////////////////

// 640x480 at 60 Hz
`define DISP_RST_H_TOTAL    16'd800
`define DISP_RST_H_END_DISP 16'd640
`define DISP_RST_H_SRT_SYNC 16'd656
`define DISP_RST_H_END_SYNC 16'd752
`define DISP_RST_V_TOTAL    16'd525
`define DISP_RST_V_END_DISP 16'd480
`define DISP_RST_V_SRT_SYNC 16'd490
`define DISP_RST_V_END_SYNC 16'd492

`define DISP_RST_FB_WIDTH   12'd640
`define DISP_RST_FB_HEIGHT  12'd480
`define DISP_RST_BG_COLOR   24'hFFFFFF

`endif

/* disp_pkg.sv */
`include "disp_consts.svh"

package disp_pkg;

  // Word index of the register port, byte address bits 7:2
  typedef enum logic [`DISP_REG_IDX_W-1:0] {
    ENABLE     = 6'h00,
    POLARITY   = 6'h02,
    H_TOTAL    = 6'h08,
    H_END_DISP = 6'h09,
    H_SRT_SYNC = 6'h0A,
    H_END_SYNC = 6'h0B,
    V_TOTAL    = 6'h0C,
    V_END_DISP = 6'h0D,
    V_SRT_SYNC = 6'h0E,
    V_END_SYNC = 6'h0F,
    FB_COMMIT  = 6'h10,
    FB_WIDTH   = 6'h14,
    FB_HEIGHT  = 6'h15,
    FB_DEPTH   = 6'h16,
    BG_COLOR   = 6'h18
  } disp_reg_e;

  // Sync polarity bits, 1 means active low
  typedef struct packed {
    logic [`DISP_CNT_W-1:0] h_total;
    logic [`DISP_CNT_W-1:0] h_end_disp;
    logic [`DISP_CNT_W-1:0] h_srt_sync;
    logic [`DISP_CNT_W-1:0] h_end_sync;
    logic [`DISP_CNT_W-1:0] v_total;
    logic [`DISP_CNT_W-1:0] v_end_disp;
    logic [`DISP_CNT_W-1:0] v_srt_sync;
    logic [`DISP_CNT_W-1:0] v_end_sync;
    logic                   hsync_pol;
    logic                   vsync_pol;
  } disp_timing_t;

  // Committed framebuffer settings
  typedef struct packed {
    logic [`DISP_FB_DIM_W-1:0] width;
    logic [`DISP_FB_DIM_W-1:0] height;
    logic                      depth;
    logic                      fetch_en;
    logic [`DISP_COLOR_W-1:0]  bg_color;
  } disp_fb_cfg_t;

  typedef struct packed {
    logic                    we;
    logic [`DISP_REG_AW-1:0] addr;
    logic [`DISP_DATA_W-1:0] wdata;
  } disp_reg_req_t;

  typedef struct packed {
    logic                        bank;
    logic [`DISP_LB_WORD_AW-1:0] addr;
    logic [`DISP_DATA_W-1:0]     data;
  } disp_lb_wr_t;

  typedef struct packed {
    logic                        en;
    logic                        bank;
    logic [`DISP_LB_WORD_AW-1:0] addr;
    logic                        half_sel;
  } disp_lb_rd_t;

  typedef struct packed {
    logic active;
    logic in_fb;
    logic half_sel;
  } disp_video_t;

endpackage

/* disp_ctrl_regs.sv */
`timescale 1ns/1ps
`include "disp_consts.svh"

module disp_ctrl_regs import disp_pkg::*; (
  input  logic                    pxl_clk_i,
  input  logic                    rst_ni,
  input  logic                    ctrl_en_i,
  input  disp_reg_req_t           ctrl_req_i,
  output logic [`DISP_DATA_W-1:0] ctrl_rddata_o,
  input  logic                    frame_end_i,
  output logic                    enable_o,
  output disp_timing_t            timing_o,
  output disp_fb_cfg_t            fb_cfg_o
);

  localparam disp_timing_t timing_rst = '{
    h_total:    `DISP_RST_H_TOTAL,
    h_end_disp: `DISP_RST_H_END_DISP,
    h_srt_sync: `DISP_RST_H_SRT_SYNC,
    h_end_sync: `DISP_RST_H_END_SYNC,
    v_total:    `DISP_RST_V_TOTAL,
    v_end_disp: `DISP_RST_V_END_DISP,
    v_srt_sync: `DISP_RST_V_SRT_SYNC,
    v_end_sync: `DISP_RST_V_END_SYNC,
    hsync_pol:  1'b1,
    vsync_pol:  1'b1
  };

  localparam disp_fb_cfg_t fb_rst = '{
    width:    `DISP_RST_FB_WIDTH,
    height:   `DISP_RST_FB_HEIGHT,
    depth:    1'b0,
    fetch_en: 1'b0,
    bg_color: `DISP_RST_BG_COLOR
  };

  disp_reg_e               reg_idx;
  logic                    wr_req;
  logic [`DISP_DATA_W-1:0] wdata;
  logic [`DISP_DATA_W-1:0] rd_data;
  logic                    enable_q;
  logic                    commit_q;
  disp_timing_t            timing_q;
  disp_fb_cfg_t            fb_stage_q;
  disp_fb_cfg_t            fb_live_q;

  assign reg_idx = disp_reg_e'(ctrl_req_i.addr[`DISP_REG_AW-1:`DISP_REG_IDX_LSB]);
  assign wr_req  = ctrl_en_i && ctrl_req_i.we;
  assign wdata   = ctrl_req_i.wdata;

  ////////////////////////////////
  // Enable and timing
  ////////////////////////////////

  // Timing and polarity are locked while the display runs
  always_ff @(posedge pxl_clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enable_q <= 1'b0;
      timing_q <= timing_rst;
    end else if (wr_req) begin
      if (reg_idx == ENABLE) begin
        enable_q <= wdata[0];
      end else if (!enable_q) begin
        case (reg_idx)
          POLARITY: begin
            timing_q.hsync_pol <= wdata[`DISP_POL_H_BIT];
            timing_q.vsync_pol <= wdata[`DISP_POL_V_BIT];
          end
          H_TOTAL:    timing_q.h_total    <= wdata[`DISP_CNT_W-1:0];
          H_END_DISP: timing_q.h_end_disp <= wdata[`DISP_CNT_W-1:0];
          H_SRT_SYNC: timing_q.h_srt_sync <= wdata[`DISP_CNT_W-1:0];
          H_END_SYNC: timing_q.h_end_sync <= wdata[`DISP_CNT_W-1:0];
          V_TOTAL:    timing_q.v_total    <= wdata[`DISP_CNT_W-1:0];
          V_END_DISP: timing_q.v_end_disp <= wdata[`DISP_CNT_W-1:0];
          V_SRT_SYNC: timing_q.v_srt_sync <= wdata[`DISP_CNT_W-1:0];
          V_END_SYNC: timing_q.v_end_sync <= wdata[`DISP_CNT_W-1:0];
          default: ;
        endcase
      end
    end
  end

  ////////////////////////////////
  // Framebuffer staging
  ////////////////////////////////

  always_ff @(posedge pxl_clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      commit_q   <= 1'b0;
      fb_stage_q <= fb_rst;
      fb_live_q  <= fb_rst;
    end else begin
      // Staged set goes live only between frames
      if (frame_end_i && commit_q) begin
        fb_live_q <= fb_stage_q;
        commit_q  <= 1'b0;
      end
      if (wr_req) begin
        case (reg_idx)
          FB_COMMIT: commit_q          <= wdata[0];
          FB_WIDTH:  fb_stage_q.width  <= wdata[`DISP_FB_DIM_W-1:0];
          FB_HEIGHT: fb_stage_q.height <= wdata[`DISP_FB_DIM_W-1:0];
          FB_DEPTH: begin
            fb_stage_q.depth    <= wdata[`DISP_DEPTH_BIT];
            fb_stage_q.fetch_en <= wdata[`DISP_FETCH_EN_BIT];
          end
          BG_COLOR:  fb_stage_q.bg_color <= wdata[`DISP_COLOR_W-1:0];
          default: ;
        endcase
      end
    end
  end

  // Read mux, framebuffer fields show the committed copy
  always_comb begin
    rd_data = '0;
    case (reg_idx)
      ENABLE:     rd_data = `DISP_DATA_W'(enable_q);
      POLARITY:   rd_data = `DISP_DATA_W'({timing_q.vsync_pol, timing_q.hsync_pol});
      H_TOTAL:    rd_data = `DISP_DATA_W'(timing_q.h_total);
      H_END_DISP: rd_data = `DISP_DATA_W'(timing_q.h_end_disp);
      H_SRT_SYNC: rd_data = `DISP_DATA_W'(timing_q.h_srt_sync);
      H_END_SYNC: rd_data = `DISP_DATA_W'(timing_q.h_end_sync);
      V_TOTAL:    rd_data = `DISP_DATA_W'(timing_q.v_total);
      V_END_DISP: rd_data = `DISP_DATA_W'(timing_q.v_end_disp);
      V_SRT_SYNC: rd_data = `DISP_DATA_W'(timing_q.v_srt_sync);
      V_END_SYNC: rd_data = `DISP_DATA_W'(timing_q.v_end_sync);
      FB_COMMIT:  rd_data = `DISP_DATA_W'(commit_q);
      FB_WIDTH:   rd_data = `DISP_DATA_W'(fb_live_q.width);
      FB_HEIGHT:  rd_data = `DISP_DATA_W'(fb_live_q.height);
      FB_DEPTH:   rd_data = `DISP_DATA_W'({fb_live_q.fetch_en, fb_live_q.depth});
      BG_COLOR:   rd_data = `DISP_DATA_W'(fb_live_q.bg_color);
      default:    rd_data = '0;
    endcase
  end

  // Read data holds until the next access
  always_ff @(posedge pxl_clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_rddata_o <= '0;
    end else if (ctrl_en_i) begin
      ctrl_rddata_o <= rd_data;
    end
  end

  assign enable_o = enable_q;
  assign timing_o = timing_q;
  assign fb_cfg_o = fb_live_q;

endmodule

/* disp_timing_gen.sv */
`timescale 1ns/1ps
`include "disp_consts.svh"

module disp_timing_gen import disp_pkg::*; (
  input  logic         pxl_clk_i,
  input  logic         rst_ni,
  input  logic         enable_i,
  input  disp_timing_t timing_i,
  input  disp_fb_cfg_t fb_cfg_i,
  output logic         hsync_o,
  output logic         vsync_o,
  output disp_video_t  video_o,
  output logic         frame_end_o,
  output logic         line_req_o,
  output logic         line_bank_o,
  output disp_lb_rd_t  lb_rd_o
);

  logic [`DISP_CNT_W-1:0] h_cnt;
  logic [`DISP_CNT_W-1:0] v_cnt;
  logic                   h_last;
  logic                   v_last;
  logic                   h_sync_win;
  logic                   v_sync_win;
  logic                   disp_win;
  logic                   line_end;
  logic                   frame_end;
  logic                   in_fb;

  assign h_last = h_cnt == timing_i.h_total - `DISP_CNT_W'(1);
  assign v_last = v_cnt == timing_i.v_total - `DISP_CNT_W'(1);

  // Counters sit at zero while the display is off
  always_ff @(posedge pxl_clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (!enable_i) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (h_last) begin
      h_cnt <= '0;
      v_cnt <= v_last ? '0 : v_cnt + `DISP_CNT_W'(1);
    end else begin
      h_cnt <= h_cnt + `DISP_CNT_W'(1);
    end
  end

  ////////////////////////////////
  // Decode from counters
  ////////////////////////////////

  assign h_sync_win = h_cnt >= timing_i.h_srt_sync && h_cnt < timing_i.h_end_sync;
  assign v_sync_win = v_cnt >= timing_i.v_srt_sync && v_cnt < timing_i.v_end_sync;
  assign disp_win   = h_cnt < timing_i.h_end_disp && v_cnt < timing_i.v_end_disp;
  assign line_end   = h_cnt == timing_i.h_end_disp && v_cnt < timing_i.v_end_disp;
  assign frame_end  = h_cnt == timing_i.h_end_disp &&
                      v_cnt == timing_i.v_end_disp - `DISP_CNT_W'(1);

  assign in_fb = fb_cfg_i.fetch_en &&
                 h_cnt < `DISP_CNT_W'(fb_cfg_i.width) &&
                 v_cnt < `DISP_CNT_W'(fb_cfg_i.height);

  // Line parity picks the bank; 16 bpp packs two pixels per word
  assign lb_rd_o.en       = in_fb;
  assign lb_rd_o.bank     = v_cnt[0];
  assign lb_rd_o.addr     = fb_cfg_i.depth ? h_cnt[`DISP_LB_WORD_AW:1]
                                           : h_cnt[`DISP_LB_WORD_AW-1:0];
  assign lb_rd_o.half_sel = h_cnt[0];

  // Video stage, lines up with the buffer read data
  always_ff @(posedge pxl_clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hsync_o     <= 1'b0;
      vsync_o     <= 1'b0;
      video_o     <= '0;
      frame_end_o <= 1'b0;
      line_req_o  <= 1'b0;
      line_bank_o <= 1'b0;
    end else begin
      // Sync output is the window flipped by the polarity bit
      hsync_o          <= enable_i && (h_sync_win ^ timing_i.hsync_pol);
      vsync_o          <= enable_i && (v_sync_win ^ timing_i.vsync_pol);
      video_o.active   <= enable_i && disp_win;
      video_o.in_fb    <= in_fb;
      video_o.half_sel <= lb_rd_o.half_sel;
      frame_end_o      <= enable_i && frame_end;
      line_req_o       <= enable_i && fb_cfg_i.fetch_en && line_end;
      if (line_end) begin
        line_bank_o <= ~v_cnt[0];
      end
    end
  end

endmodule

/* disp_line_buffer.sv */
`timescale 1ns/1ps
`include "disp_consts.svh"

module disp_line_buffer import disp_pkg::*; (
  input  logic                    pxl_clk_i,
  input  logic                    wr_en_i,
  input  disp_lb_wr_t             wr_i,
  input  disp_lb_rd_t             rd_i,
  output logic [`DISP_DATA_W-1:0] rd_data_o
);

  localparam int unsigned depth = 2 * (2 ** `DISP_LB_WORD_AW);

  // Two banks, bank bit on top of the word address
  logic [`DISP_DATA_W-1:0] mem [depth];

  always_ff @(posedge pxl_clk_i) begin
    if (wr_en_i) begin
      mem[{wr_i.bank, wr_i.addr}] <= wr_i.data;
    end
  end

  // Read register keeps its value while reads are idle
  always_ff @(posedge pxl_clk_i) begin
    if (rd_i.en) begin
      rd_data_o <= mem[{rd_i.bank, rd_i.addr}];
    end
  end

endmodule

/* disp_pixel_fmt.sv */
`timescale 1ns/1ps
`include "disp_consts.svh"

module disp_pixel_fmt import disp_pkg::*; (
  input  disp_video_t             video_i,
  input  disp_fb_cfg_t            fb_cfg_i,
  input  logic [`DISP_DATA_W-1:0] rd_data_i,
  output logic [`DISP_CH_W-1:0]   red_o,
  output logic [`DISP_CH_W-1:0]   green_o,
  output logic [`DISP_CH_W-1:0]   blue_o
);

  // r5g6b5 to 24 bit, top bits fill the low end
  function automatic logic [`DISP_COLOR_W-1:0] unpack565(input logic [15:0] px);
    logic [`DISP_CH_W-1:0] r;
    logic [`DISP_CH_W-1:0] g;
    logic [`DISP_CH_W-1:0] b;
    r = {px[4:0], px[4:2]};
    g = {px[10:5], px[10:9]};
    b = {px[15:11], px[15:13]};
    return {b, g, r};
  endfunction

  logic [15:0]              half_word;
  logic [`DISP_COLOR_W-1:0] color;

  // Odd pixels live in the upper half
  assign half_word = video_i.half_sel ? rd_data_i[31:16] : rd_data_i[15:0];

  always_comb begin
    if (!video_i.active) begin
      color = '0;
    end else if (!video_i.in_fb) begin
      color = fb_cfg_i.bg_color;
    end else if (fb_cfg_i.depth) begin
      color = unpack565(half_word);
    end else begin
      color = rd_data_i[`DISP_COLOR_W-1:0];
    end
  end

  ////////////////////////////////
  // Channel split
  ////////////////////////////////

  assign red_o   = color[7:0];
  assign green_o = color[15:8];
  assign blue_o  = color[23:16];

endmodule

/* disp_top.sv */
`timescale 1ns/1ps
`include "disp_consts.svh"

module disp_top import disp_pkg::*; (
  input  logic                    pxl_clk_i,
  input  logic                    rst_ni,
  // Register port
  input  logic                    ctrl_en_i,
  input  disp_reg_req_t           ctrl_req_i,
  output logic [`DISP_DATA_W-1:0] ctrl_rddata_o,
  // Line buffer loading
  input  logic                    lb_wr_en_i,
  input  disp_lb_wr_t             lb_wr_i,
  output logic                    line_req_o,
  output logic                    line_bank_o,
  // Video out
  output logic [`DISP_CH_W-1:0]   red_o,
  output logic [`DISP_CH_W-1:0]   green_o,
  output logic [`DISP_CH_W-1:0]   blue_o,
  output logic                    pixel_o,
  output logic                    hsync_o,
  output logic                    vsync_o
);

  logic                    enable;
  logic                    frame_end;
  disp_timing_t            timing;
  disp_fb_cfg_t            fb_cfg;
  disp_video_t             video;
  disp_lb_rd_t             lb_rd;
  logic [`DISP_DATA_W-1:0] lb_rd_data;

  disp_ctrl_regs u_regs (
    .pxl_clk_i     (pxl_clk_i),
    .rst_ni        (rst_ni),
    .ctrl_en_i     (ctrl_en_i),
    .ctrl_req_i    (ctrl_req_i),
    .ctrl_rddata_o (ctrl_rddata_o),
    .frame_end_i   (frame_end),
    .enable_o      (enable),
    .timing_o      (timing),
    .fb_cfg_o      (fb_cfg)
  );

  disp_timing_gen u_timing (
    .pxl_clk_i   (pxl_clk_i),
    .rst_ni      (rst_ni),
    .enable_i    (enable),
    .timing_i    (timing),
    .fb_cfg_i    (fb_cfg),
    .hsync_o     (hsync_o),
    .vsync_o     (vsync_o),
    .video_o     (video),
    .frame_end_o (frame_end),
    .line_req_o  (line_req_o),
    .line_bank_o (line_bank_o),
    .lb_rd_o     (lb_rd)
  );

  disp_line_buffer u_lbuf (
    .pxl_clk_i (pxl_clk_i),
    .wr_en_i   (lb_wr_en_i),
    .wr_i      (lb_wr_i),
    .rd_i      (lb_rd),
    .rd_data_o (lb_rd_data)
  );

  disp_pixel_fmt u_fmt (
    .video_i   (video),
    .fb_cfg_i  (fb_cfg),
    .rd_data_i (lb_rd_data),
    .red_o     (red_o),
    .green_o   (green_o),
    .blue_o    (blue_o)
  );

  assign pixel_o = video.active;

endmodule

/* disp_props.sv */
`timescale 1ns/1ps
`include "disp_consts.svh"

module disp_props import disp_pkg::*; (
  input logic                  pxl_clk_i,
  input logic                  rst_ni,
  input logic                  enable_i,
  input disp_timing_t          timing_i,
  input logic                  pixel_i,
  input logic                  line_req_i,
  input logic                  hsync_i,
  input logic [`DISP_CH_W-1:0] red_i,
  input logic [`DISP_CH_W-1:0] green_i,
  input logic [`DISP_CH_W-1:0] blue_i
);

  int unsigned            fail_cnt = 0;
  logic                   en_q;
  logic                   hs_act;
  logic [`DISP_CNT_W-1:0] hs_len;

  // Sync outputs lag enable by one cycle
  assign hs_act = en_q && (hsync_i != timing_i.hsync_pol);

  always_ff @(posedge pxl_clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      en_q   <= 1'b0;
      hs_len <= '0;
    end else begin
      en_q   <= enable_i;
      hs_len <= hs_act ? hs_len + `DISP_CNT_W'(1) : '0;
    end
  end

  //////////////////////////////
  // Output rules
  //////////////////////////////

  assert property (@(posedge pxl_clk_i) disable iff (!rst_ni)
    !pixel_i |-> {red_i, green_i, blue_i} == '0)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("colour is not black while pixel_o is low");
    end

  assert property (@(posedge pxl_clk_i) disable iff (!rst_ni)
    line_req_i |=> !line_req_i)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("line_req_o held high for two cycles");
    end

  assert property (@(posedge pxl_clk_i) disable iff (!rst_ni)
    !enable_i |=> !pixel_i)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("pixel_o high while the display is disabled");
    end

  // Phase cut short by a disable is not a full phase
  assert property (@(posedge pxl_clk_i) disable iff (!rst_ni)
    $fell(hs_act) && en_q |-> hs_len == timing_i.h_end_sync - timing_i.h_srt_sync)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("hsync active phase has the wrong length");
    end

endmodule

bind disp_top disp_props props_inst (
  .pxl_clk_i  (pxl_clk_i),
  .rst_ni     (rst_ni),
  .enable_i   (enable),
  .timing_i   (timing),
  .pixel_i    (pixel_o),
  .line_req_i (line_req_o),
  .hsync_i    (hsync_o),
  .red_i      (red_o),
  .green_i    (green_o),
  .blue_i     (blue_o)
);

/* tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  // 100 ns pixel clock
  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // Reset held for 5 cycles, released on a falling edge
  initial begin
    rst_no = 1'b0;
    repeat (5) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

/* tb_disp.sv */
`timescale 1ns/1ps
`include "disp_consts.svh"

module tb_disp import disp_pkg::*; ();

  // 8 frames of 120 cycles plus register setup and buffer loading
  localparam int unsigned timeout_cyc = 1500;

  localparam disp_timing_t timing_defaults = '{
    h_total:    `DISP_RST_H_TOTAL,
    h_end_disp: `DISP_RST_H_END_DISP,
    h_srt_sync: `DISP_RST_H_SRT_SYNC,
    h_end_sync: `DISP_RST_H_END_SYNC,
    v_total:    `DISP_RST_V_TOTAL,
    v_end_disp: `DISP_RST_V_END_DISP,
    v_srt_sync: `DISP_RST_V_SRT_SYNC,
    v_end_sync: `DISP_RST_V_END_SYNC,
    hsync_pol:  1'b1,
    vsync_pol:  1'b1
  };

  localparam disp_fb_cfg_t fb_defaults = '{
    width:    `DISP_RST_FB_WIDTH,
    height:   `DISP_RST_FB_HEIGHT,
    depth:    1'b0,
    fetch_en: 1'b0,
    bg_color: `DISP_RST_BG_COLOR
  };

  logic                    clk;
  logic                    rst_n;
  logic                    ctrl_en;
  disp_reg_req_t           ctrl_req;
  logic [`DISP_DATA_W-1:0] ctrl_rddata;
  logic                    lb_wr_en;
  disp_lb_wr_t             lb_wr;
  logic                    line_req;
  logic                    line_bank;
  logic [7:0]              red;
  logic [7:0]              green;
  logic [7:0]              blue;
  logic                    pixel;
  logic                    hsync;
  logic                    vsync;

  int unsigned             err_cnt = 0;
  int unsigned             prop_errs;
  int unsigned             cycle_cnt = 0;
  int                      px_cnt;
  int                      lr_cnt;

  // Reference model state
  disp_timing_t            tm_m;
  disp_fb_cfg_t            fbs_m;
  disp_fb_cfg_t            fb_m;
  logic [31:0]             lb_m [512];
  logic                    en_m;
  logic                    commit_m;
  logic                    fe_m;
  logic [15:0]             h_m;
  logic [15:0]             v_m;
  logic                    disp_m;
  logic                    in_fb_m;
  logic [31:0]             word_m;
  logic                    exp_hs;
  logic                    exp_vs;
  logic                    exp_px;
  logic                    exp_lr;
  logic                    exp_lb;
  logic [23:0]             exp_rgb;

  tb_clk_gen clk_gen_inst (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  disp_top disp_top_inst (
    .pxl_clk_i     (clk),
    .rst_ni        (rst_n),
    .ctrl_en_i     (ctrl_en),
    .ctrl_req_i    (ctrl_req),
    .ctrl_rddata_o (ctrl_rddata),
    .lb_wr_en_i    (lb_wr_en),
    .lb_wr_i       (lb_wr),
    .line_req_o    (line_req),
    .line_bank_o   (line_bank),
    .red_o         (red),
    .green_o       (green),
    .blue_o        (blue),
    .pixel_o       (pixel),
    .hsync_o       (hsync),
    .vsync_o       (vsync)
  );

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Expected 24-bit colour of one buffer word, blue in the top byte
  function automatic logic [23:0] expect_color(input logic [31:0] word, input logic odd,
                                               input logic bpp16);
    logic [15:0] half;
    logic [7:0]  r;
    logic [7:0]  g;
    logic [7:0]  b;
    half = odd ? word[31:16] : word[15:0];
    r = (8'(half[4:0]) << 3) | (8'(half[4:0]) >> 2);
    g = (8'(half[10:5]) << 2) | (8'(half[10:5]) >> 4);
    b = (8'(half[15:11]) << 3) | (8'(half[15:11]) >> 2);
    return bpp16 ? {b, g, r} : word[23:0];
  endfunction

  assign disp_m  = h_m < tm_m.h_end_disp && v_m < tm_m.v_end_disp;
  assign in_fb_m = fb_m.fetch_en && h_m < 16'(fb_m.width) && v_m < 16'(fb_m.height);
  assign word_m  = lb_m[{v_m[0], fb_m.depth ? h_m[8:1] : h_m[7:0]}];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      en_m     <= 1'b0;
      commit_m <= 1'b0;
      fe_m     <= 1'b0;
      fb_m     <= fb_defaults;
      h_m      <= '0;
      v_m      <= '0;
      exp_hs   <= 1'b0;
      exp_vs   <= 1'b0;
      exp_px   <= 1'b0;
      exp_lr   <= 1'b0;
      exp_lb   <= 1'b0;
      exp_rgb  <= '0;
    end else begin
      exp_hs  <= en_m && ((h_m >= tm_m.h_srt_sync && h_m < tm_m.h_end_sync) != tm_m.hsync_pol);
      exp_vs  <= en_m && ((v_m >= tm_m.v_srt_sync && v_m < tm_m.v_end_sync) != tm_m.vsync_pol);
      exp_px  <= en_m && disp_m;
      exp_rgb <= !(en_m && disp_m) ? 24'h0 :
                 in_fb_m ? expect_color(word_m, h_m[0], fb_m.depth) : fb_m.bg_color;
      exp_lr  <= en_m && fb_m.fetch_en && h_m == tm_m.h_end_disp && v_m < tm_m.v_end_disp;
      if (h_m == tm_m.h_end_disp && v_m < tm_m.v_end_disp) begin
        exp_lb <= ~v_m[0];
      end
      fe_m <= en_m && h_m == tm_m.h_end_disp && v_m == tm_m.v_end_disp - 16'd1;
      if (fe_m && commit_m) begin
        fb_m     <= fbs_m;
        commit_m <= 1'b0;
      end
      // Enable and commit follow the register port
      if (ctrl_en && ctrl_req.we && ctrl_req.addr[7:2] == ENABLE) begin
        en_m <= ctrl_req.wdata[0];
      end
      if (ctrl_en && ctrl_req.we && ctrl_req.addr[7:2] == FB_COMMIT) begin
        commit_m <= ctrl_req.wdata[0];
      end
      if (!en_m) begin
        h_m <= '0;
        v_m <= '0;
      end else if (h_m == tm_m.h_total - 16'd1) begin
        h_m <= '0;
        v_m <= (v_m == tm_m.v_total - 16'd1) ? 16'd0 : v_m + 16'd1;
      end else begin
        h_m <= h_m + 16'd1;
      end
    end
  end

  //////////////////////////////
  // Checks and bus tasks
  //////////////////////////////

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      err_cnt++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  // Outputs are compared mid-cycle, away from the rising edge
  always @(negedge clk) begin
    if (rst_n) begin
      check_val("hsync_o", 32'(hsync), 32'(exp_hs));
      check_val("vsync_o", 32'(vsync), 32'(exp_vs));
      check_val("pixel_o", 32'(pixel), 32'(exp_px));
      check_val("line_req_o", 32'(line_req), 32'(exp_lr));
      check_val("{blue_o,green_o,red_o}", 32'({blue, green, red}), 32'(exp_rgb));
      if (exp_lr) begin
        check_val("line_bank_o", 32'(line_bank), 32'(exp_lb));
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_cyc) begin
      $display("Timeout: the test program did not finish within %0d cycles", timeout_cyc);
      $display("Done: errors found");
      $finish;
    end
  end

  // Entered and left on a falling edge, one cycle per access
  task automatic access_reg(input logic we, input disp_reg_e idx, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    ctrl_en        = 1'b1;
    ctrl_req.we    = we;
    ctrl_req.addr  = {idx, 2'b00};
    ctrl_req.wdata = wdata;
    @(negedge clk);
    ctrl_en = 1'b0;
    rdata   = ctrl_rddata;
  endtask

  task automatic write_reg(input disp_reg_e idx, input logic [31:0] wdata);
    logic [31:0] unused;
    access_reg(1'b1, idx, wdata, unused);
  endtask

  task automatic check_reg(input disp_reg_e idx, input logic [31:0] exp);
    logic [31:0] got;
    access_reg(1'b0, idx, 32'h0, got);
    check_val("ctrl_rddata_o", got, exp);
  endtask

  // Commit reads back 1 until the model sees the frame end
  task automatic poll_commit();
    logic exp;
    exp = 1'b1;
    while (exp) begin
      exp = commit_m;
      check_reg(FB_COMMIT, 32'(exp));
    end
  endtask

  task automatic program_timing(input logic [1:0] pol);
    write_reg(H_TOTAL, 32'd20);
    write_reg(H_END_DISP, 32'd12);
    write_reg(H_SRT_SYNC, 32'd14);
    write_reg(H_END_SYNC, 32'd17);
    write_reg(V_TOTAL, 32'd6);
    write_reg(V_END_DISP, 32'd4);
    write_reg(V_SRT_SYNC, 32'd4);
    write_reg(V_END_SYNC, 32'd5);
    write_reg(POLARITY, 32'(pol));
    tm_m = '{h_total: 16'd20, h_end_disp: 16'd12, h_srt_sync: 16'd14, h_end_sync: 16'd17,
             v_total: 16'd6, v_end_disp: 16'd4, v_srt_sync: 16'd4, v_end_sync: 16'd5,
             hsync_pol: pol[0], vsync_pol: pol[1]};
  endtask

  // Random words into the first 8 words of both banks
  task automatic load_line_buffer();
    logic [31:0] word;
    for (int b = 0; b < 2; b++) begin
      for (int w = 0; w < 8; w++) begin
        word          = $urandom();
        lb_wr_en      = 1'b1;
        lb_wr.bank    = b[0];
        lb_wr.addr    = w[7:0];
        lb_wr.data    = word;
        lb_m[{b[0], w[7:0]}] = word;
        @(negedge clk);
      end
    end
    lb_wr_en = 1'b0;
  endtask

  task automatic run_cycles(input int n, output int pixels, output int reqs);
    pixels = 0;
    reqs   = 0;
    repeat (n) begin
      @(negedge clk);
      pixels += int'(pixel);
      reqs   += int'(line_req);
    end
  endtask

  //////////////////////////////
  // Test program
  //////////////////////////////

  initial begin
    void'($urandom(32'hd1654524));
    ctrl_en  = 1'b0;
    ctrl_req = '0;
    lb_wr_en = 1'b0;
    lb_wr    = '0;
    tm_m     = timing_defaults;
    fbs_m    = fb_defaults;
    @(posedge rst_n);
    @(negedge clk);

    // Reset defaults
    check_reg(H_TOTAL, 32'(`DISP_RST_H_TOTAL));
    check_reg(H_END_DISP, 32'(`DISP_RST_H_END_DISP));
    check_reg(H_SRT_SYNC, 32'(`DISP_RST_H_SRT_SYNC));
    check_reg(H_END_SYNC, 32'(`DISP_RST_H_END_SYNC));
    check_reg(V_TOTAL, 32'(`DISP_RST_V_TOTAL));
    check_reg(V_END_DISP, 32'(`DISP_RST_V_END_DISP));
    check_reg(V_SRT_SYNC, 32'(`DISP_RST_V_SRT_SYNC));
    check_reg(V_END_SYNC, 32'(`DISP_RST_V_END_SYNC));
    check_reg(POLARITY, 32'd3);
    check_reg(ENABLE, 32'd0);
    check_reg(FB_COMMIT, 32'd0);

    // Timing lock while enabled
    write_reg(ENABLE, 32'd1);
    write_reg(H_TOTAL, 32'd20);
    check_reg(H_TOTAL, 32'(`DISP_RST_H_TOTAL));
    write_reg(ENABLE, 32'd0);
    write_reg(H_TOTAL, 32'd20);
    check_reg(H_TOTAL, 32'd20);

    // Small raster, active high then active low sync
    program_timing(2'b00);
    write_reg(ENABLE, 32'd1);
    repeat (4) @(negedge clk);
    run_cycles(240, px_cnt, lr_cnt);
    check_val("pixel_o count", 32'(px_cnt), 32'd96);
    write_reg(ENABLE, 32'd0);
    write_reg(POLARITY, 32'd3);
    tm_m.hsync_pol = 1'b1;
    tm_m.vsync_pol = 1'b1;
    write_reg(ENABLE, 32'd1);
    repeat (4) @(negedge clk);
    run_cycles(120, px_cnt, lr_cnt);
    check_val("pixel_o count", 32'(px_cnt), 32'd48);

    // 8x3 framebuffer at 32 bpp
    load_line_buffer();
    write_reg(FB_WIDTH, 32'd8);
    fbs_m.width = 12'd8;
    write_reg(FB_HEIGHT, 32'd3);
    fbs_m.height = 12'd3;
    write_reg(FB_DEPTH, 32'd2);
    fbs_m.fetch_en = 1'b1;
    write_reg(BG_COLOR, 32'h3355AA);
    fbs_m.bg_color = 24'h3355AA;
    write_reg(FB_COMMIT, 32'd1);
    poll_commit();
    check_reg(FB_DEPTH, 32'd2);
    run_cycles(120, px_cnt, lr_cnt);
    check_val("line_req_o count", 32'(lr_cnt), 32'd4);

    // Same words as r5g6b5 pairs
    write_reg(FB_DEPTH, 32'd3);
    fbs_m.depth = 1'b1;
    write_reg(FB_COMMIT, 32'd1);
    poll_commit();
    run_cycles(120, px_cnt, lr_cnt);

    // Staged values stay hidden until the commit lands
    write_reg(FB_WIDTH, 32'd5);
    fbs_m.width = 12'd5;
    write_reg(BG_COLOR, 32'h00C0FF);
    fbs_m.bg_color = 24'h00C0FF;
    check_reg(FB_WIDTH, 32'd8);
    check_reg(BG_COLOR, 32'h3355AA);
    run_cycles(60, px_cnt, lr_cnt);
    write_reg(FB_COMMIT, 32'd1);
    poll_commit();
    check_reg(FB_WIDTH, 32'd5);
    check_reg(BG_COLOR, 32'h00C0FF);
    run_cycles(120, px_cnt, lr_cnt);
    check_val("pixel_o count", 32'(px_cnt), 32'd48);
    check_val("line_req_o count", 32'(lr_cnt), 32'd4);

    prop_errs = disp_top_inst.props_inst.fail_cnt;
    $display("Errors: %0d value mismatches, %0d assertion failures", err_cnt, prop_errs);
    if (err_cnt == 0 && prop_errs == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+.
disp_pkg.sv
disp_ctrl_regs.sv
disp_timing_gen.sv
disp_line_buffer.sv
disp_pixel_fmt.sv
disp_top.sv
disp_props.sv
tb_clk_gen.sv
tb_disp.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the display controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_disp -f flist.f -o tb_disp_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Keep running past the first assertion failure so the testbench can report
./obj_dir/tb_disp_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Done: no errors$" "$LOG"; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1
